// ==== logic/exe_pkg.sv ====
// RV64 only. Opcode values are private to this cluster and OP_NOP must stay zero for cleared stages
package exe_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int XLEN    = 64;
    localparam int TAG_W   = 6;                 // Reorder tag
    localparam int REG_W   = 5;                 // Architectural register index
    localparam int HALF_W  = XLEN / 2;          // Word ops and multiplier split
    localparam int PP_W    = XLEN + HALF_W;     // One 64x32 partial product
    localparam int SHAMT_W = $clog2(XLEN);      // Shift amount taken from rs2

    // ------------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        OP_NOP    = 5'd0,   // Bubble and reset value
        // Integer ALU
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_ADDW,
        // M-extension multiplies
        OP_MUL,
        OP_MULH,
        OP_MULHSU,
        OP_MULHU,
        OP_MULW
    } exe_op_e;

    // ------------------------------------------------------------------------
    // Issue and writeback buses
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic             valid;
        exe_op_e          op;
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data_rs1;
        logic [XLEN-1:0]  data_rs2;
    } rr_exe_instr_t;                           // 145 bits

    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  result;
    } exe_wb_instr_t;                           // 76 bits

    // Unit ownership, decoded from op alone
    function automatic logic is_alu_op(exe_op_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL,
                          OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_ADDW};
    endfunction

    function automatic logic is_mul_op(exe_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
    endfunction

endpackage

// ==== logic/mul_unit.sv ====
// MULW done in 1 cycle, 64-bit multiplies in 2; issuer must not send MULW right after a 64-bit one
module mul_unit
    import exe_pkg::*;
(
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          flush_i,          // Kills both stages and the incoming op
    input  rr_exe_instr_t instruction_i,
    output exe_wb_instr_t instruction_o
);

    // Per-stage control travelling alongside the datapath
    typedef struct packed {
        logic             valid;
        exe_op_e          op;
        logic             neg;              // Product must be negated
        logic [REG_W-1:0] rd;
        logic [TAG_W-1:0] tag;
    } mul_ctrl_t;

    logic              take;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   rs2;
    logic [XLEN-1:0]   src1_ext;
    logic [XLEN-1:0]   src2_ext;
    logic              src1_neg;
    logic              src2_neg;
    logic [XLEN-1:0]   mag1_d;
    logic [XLEN-1:0]   mag2_d;
    logic [XLEN-1:0]   mag1_q;
    logic [XLEN-1:0]   mag2_q;
    mul_ctrl_t         s1_d;
    mul_ctrl_t         s1_q;
    mul_ctrl_t         s2_q;
    logic              s1_is_word;
    logic [PP_W-1:0]   pp_lo_d;
    logic [PP_W-1:0]   pp_hi_d;
    logic [PP_W-1:0]   pp_lo_q;
    logic [PP_W-1:0]   pp_hi_q;
    logic [XLEN-1:0]   word_prod;
    logic [XLEN-1:0]   word_res;
    logic [2*XLEN-1:0] sum_128;
    logic [2*XLEN-1:0] prod_128;
    logic [XLEN-1:0]   res_64;
    exe_wb_instr_t     wb_s1;
    exe_wb_instr_t     wb_s2;

    assign rs1  = instruction_i.data_rs1;
    assign rs2  = instruction_i.data_rs2;
    assign take = instruction_i.valid && is_mul_op(instruction_i.op);

    // ------------------------------------------------------------------------
    // Stage one: sign handling and operand magnitudes
    // ------------------------------------------------------------------------
    always_comb begin
        src1_ext = rs1;
        src2_ext = rs2;
        src1_neg = 1'b0;
        src2_neg = 1'b0;
        case (instruction_i.op)
            OP_MUL, OP_MULH: begin              // Signed x signed
                src1_neg = rs1[XLEN-1];
                src2_neg = rs2[XLEN-1];
            end
            OP_MULHSU: begin                    // Only rs1 is signed
                src1_neg = rs1[XLEN-1];
            end
            OP_MULW: begin
                // Upper halves are ignored, the word sign sits in bit 31
                src1_ext = {{HALF_W{rs1[HALF_W-1]}}, rs1[HALF_W-1:0]};
                src2_ext = {{HALF_W{rs2[HALF_W-1]}}, rs2[HALF_W-1:0]};
                src1_neg = rs1[HALF_W-1];
                src2_neg = rs2[HALF_W-1];
            end
            default: begin                      // MULHU stays unsigned
            end
        endcase
    end

    assign mag1_d = src1_neg ? ~src1_ext + 1'b1 : src1_ext;
    assign mag2_d = src2_neg ? ~src2_ext + 1'b1 : src2_ext;

    assign s1_d.valid = take;
    assign s1_d.op    = instruction_i.op;
    assign s1_d.neg   = src1_neg ^ src2_neg;
    assign s1_d.rd    = instruction_i.rd;
    assign s1_d.tag   = instruction_i.tag;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            s1_q <= '0;                         // Op reads OP_NOP
        end else if (flush_i || !take) begin
            s1_q <= '0;
        end else begin
            s1_q <= s1_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            mag1_q <= mag1_d;
            mag2_q <= mag2_d;
        end
    end

    // Two 64x32 partial products from the registered magnitudes
    assign pp_lo_d = mag1_q * mag2_q[HALF_W-1:0];
    assign pp_hi_d = mag1_q * mag2_q[XLEN-1:HALF_W];

    // MULW finishes here from the low product alone
    assign s1_is_word = s1_q.valid && (s1_q.op == OP_MULW);
    assign word_prod  = s1_q.neg ? ~pp_lo_d[XLEN-1:0] + 1'b1 : pp_lo_d[XLEN-1:0];
    assign word_res   = {{HALF_W{word_prod[HALF_W-1]}}, word_prod[HALF_W-1:0]};

    assign wb_s1.valid  = s1_is_word;
    assign wb_s1.rd     = s1_q.rd;
    assign wb_s1.tag    = s1_q.tag;
    assign wb_s1.result = word_res;

    // ------------------------------------------------------------------------
    // Stage two: 128-bit sum, sign fix and half select
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            s2_q <= '0;
        end else if (flush_i || !s1_q.valid || s1_is_word) begin
            s2_q <= '0;                         // MULW already left at stage one
        end else begin
            s2_q <= s1_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_q.valid && !s1_is_word) begin
            pp_lo_q <= pp_lo_d;
            pp_hi_q <= pp_hi_d;
        end
    end

    assign sum_128  = {{(2*XLEN-PP_W){1'b0}}, pp_lo_q} + {pp_hi_q, {HALF_W{1'b0}}};
    assign prod_128 = s2_q.neg ? ~sum_128 + 1'b1 : sum_128;
    assign res_64   = (s2_q.op == OP_MUL) ? prod_128[XLEN-1:0]       // Low half
                                          : prod_128[2*XLEN-1:XLEN]; // MULH, MULHSU, MULHU

    assign wb_s2.valid  = s2_q.valid;
    assign wb_s2.rd     = s2_q.rd;
    assign wb_s2.tag    = s2_q.tag;
    assign wb_s2.result = res_64;

    // ------------------------------------------------------------------------
    // Output select
    // ------------------------------------------------------------------------
    assign instruction_o = s1_is_word ? wb_s1 : wb_s2;

    // A MULW issued one cycle after a 64-bit multiply would hide its result
    a_no_word_collision: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(s1_is_word && s2_q.valid)
    ) else $error("MULW in stage one collides with a 64-bit multiply in stage two");

    a_valid_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(instruction_o.valid)
    ) else $error("Multiply writeback valid is unknown");

endmodule

// ==== logic/int_alu.sv ====
// Register-register integer ops only with a fixed latency of one cycle and no immediates or branches
module int_alu
    import exe_pkg::*;
(
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          flush_i,
    input  rr_exe_instr_t instruction_i,
    output exe_wb_instr_t instruction_o
);

    logic               take;
    logic [XLEN-1:0]    rs1;
    logic [XLEN-1:0]    rs2;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    sum;
    logic [XLEN-1:0]    result;
    exe_wb_instr_t      wb_d;
    exe_wb_instr_t      wb_q;

    assign take  = instruction_i.valid && is_alu_op(instruction_i.op);
    assign rs1   = instruction_i.data_rs1;
    assign rs2   = instruction_i.data_rs2;
    assign shamt = rs2[SHAMT_W-1:0];            // Low 6 bits only
    assign sum   = rs1 + rs2;                   // Shared by ADD and ADDW

    // ------------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------------
    always_comb begin
        case (instruction_i.op)
            OP_ADD:  result = sum;
            OP_SUB:  result = rs1 - rs2;
            OP_AND:  result = rs1 & rs2;
            OP_OR:   result = rs1 | rs2;
            OP_XOR:  result = rs1 ^ rs2;
            OP_SLL:  result = rs1 << shamt;
            OP_SRL:  result = rs1 >> shamt;
            OP_SRA:  result = $signed(rs1) >>> shamt;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(rs2)};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, rs1 < rs2};
            OP_ADDW: result = {{HALF_W{sum[HALF_W-1]}}, sum[HALF_W-1:0]};
            default: result = '0;               // Not an ALU op
        endcase
    end

    assign wb_d.valid  = take;
    assign wb_d.rd     = instruction_i.rd;
    assign wb_d.tag    = instruction_i.tag;
    assign wb_d.result = result;

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            wb_q <= '0;
        end else if (flush_i || !take) begin
            wb_q <= '0;                         // Bubble on flush or foreign op
        end else begin
            wb_q <= wb_d;
        end
    end

    assign instruction_o = wb_q;

    // Every result traces back to an unflushed ALU issue one edge earlier
    a_valid_has_source: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        instruction_o.valid |-> $past(take && !flush_i)
    ) else $error("ALU writeback valid without a matching issue");

endmodule

// ==== logic/exe_int_cluster.sv ====
// No handshake or back-pressure and every valid writeback must be taken in the cycle it appears
module exe_int_cluster
    import exe_pkg::*;
(
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          flush_i,          // One-cycle pulse from the core
    input  rr_exe_instr_t instruction_i,    // From register read
    output exe_wb_instr_t mul_wb_o,
    output exe_wb_instr_t alu_wb_o
);

    // ------------------------------------------------------------------------
    // Issue broadcast
    // ------------------------------------------------------------------------
    // Each unit decodes ownership from op, so a bubble is ignored by both

    mul_unit u_mul_unit (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .instruction_i (instruction_i),
        .instruction_o (mul_wb_o)           // Latency 1 for MULW, else 2
    );

    int_alu u_int_alu (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .instruction_i (instruction_i),
        .instruction_o (alu_wb_o)           // Latency 1
    );

endmodule

// ==== testbench/tb_exe_int_cluster.sv ====
// Drives the cluster from one issue stream against a 128-bit model; tags are reused mod 64
module tb_exe_int_cluster
    import exe_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 2;
    localparam int N_ALU_RANDOM   = 150;
    localparam int N_ALU_CORNER   = 8;
    localparam int N_MUL_RANDOM   = 40;
    localparam int N_MULH_RANDOM  = 20;
    localparam int N_MULW         = 60;
    localparam int N_MIXED        = 200;
    localparam int N_FLUSH        = 24;
    localparam int DRAIN_CYCLES   = 8;      // Per test, covers the longest latency
    localparam int PLANNED_CYCLES = RESET_CYCLES + N_ALU_RANDOM + N_ALU_CORNER + 25
                                  + N_MUL_RANDOM + 3 * (25 + N_MULH_RANDOM) + N_MULW
                                  + N_MIXED + N_FLUSH + 6 * DRAIN_CYCLES;
    localparam int MARGIN_CYCLES  = 100;
    localparam int WATCHDOG_NS    = (PLANNED_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    // One outstanding result, looked up by its reorder tag
    typedef struct packed {
        logic             mul_port;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  result;
        logic [31:0]      due;              // Cycle at which the compare must see it
    } exp_entry_t;

    logic          clk_i = 1'b0;
    logic          rstn_i;
    logic          flush_i;
    rr_exe_instr_t instruction_i;
    exe_wb_instr_t mul_wb_o;
    exe_wb_instr_t alu_wb_o;

    exp_entry_t       expected_by_tag [int];
    int               cyc = 0;
    int               last_mul64_cyc = -10;
    logic [TAG_W-1:0] next_tag = '0;
    int               check_count = 0;
    int               error_count = 0;
    int               check_base = 0;
    int               error_base = 0;
    int               killed_count = 0;

    exe_int_cluster dut_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .instruction_i (instruction_i),
        .mul_wb_o      (mul_wb_o),
        .alu_wb_o      (alu_wb_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // -------------------------------------------------------------------------
    // Reference model
    // -------------------------------------------------------------------------
    function automatic logic [XLEN-1:0] expected_result(exe_op_e op, logic [63:0] a,
                                                        logic [63:0] b);
        logic [127:0] ua;
        logic [127:0] ub;
        logic [127:0] sa;
        logic [127:0] sb;
        logic [127:0] prod;
        logic [63:0]  res;
        ua   = {64'd0, a};
        ub   = {64'd0, b};
        sa   = {{64{a[63]}}, a};            // Widened signed operands
        sb   = {{64{b[63]}}, b};
        prod = 128'd0;
        res  = 64'd0;
        case (op)
            OP_ADD:    res = a + b;
            OP_SUB:    res = a - b;
            OP_AND:    res = a & b;
            OP_OR:     res = a | b;
            OP_XOR:    res = a ^ b;
            OP_SLL:    res = a << b[5:0];
            OP_SRL:    res = a >> b[5:0];
            OP_SRA:    res = $unsigned($signed(a) >>> b[5:0]);
            OP_SLT:    res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_SLTU:   res = (a < b) ? 64'd1 : 64'd0;
            OP_ADDW: begin
                prod = ua + ub;
                res  = {{32{prod[31]}}, prod[31:0]};
            end
            OP_MUL: begin
                prod = ua * ub;
                res  = prod[63:0];
            end
            OP_MULH: begin
                prod = sa * sb;
                res  = prod[127:64];
            end
            OP_MULHSU: begin
                prod = sa * ub;
                res  = prod[127:64];
            end
            OP_MULHU: begin
                prod = ua * ub;
                res  = prod[127:64];
            end
            OP_MULW: begin
                prod = {96'd0, a[31:0]} * {96'd0, b[31:0]};
                res  = {{32{prod[31]}}, prod[31:0]};
            end
            default:   res = 64'd0;
        endcase
        return res;
    endfunction

    function automatic int latency_of(exe_op_e op);
        case (op)
            OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU: return 2;
            default:                              return 1;
        endcase
    endfunction

    function automatic logic goes_to_mul(exe_op_e op);
        return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
    endfunction

    function automatic exe_op_e alu_op_at(int i);
        case (i)
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_AND;
            3:       return OP_OR;
            4:       return OP_XOR;
            5:       return OP_SLL;
            6:       return OP_SRL;
            7:       return OP_SRA;
            8:       return OP_SLT;
            9:       return OP_SLTU;
            default: return OP_ADDW;
        endcase
    endfunction

    function automatic exe_op_e mul64_op_at(int i);
        case (i)
            0:       return OP_MUL;
            1:       return OP_MULH;
            2:       return OP_MULHSU;
            default: return OP_MULHU;
        endcase
    endfunction

    function automatic logic [63:0] corner_value(int i);
        case (i)
            0:       return 64'h0000_0000_0000_0000;
            1:       return 64'h0000_0000_0000_0001;
            2:       return 64'hffff_ffff_ffff_ffff;
            3:       return 64'h8000_0000_0000_0000;    // Most negative
            default: return 64'h7fff_ffff_ffff_ffff;
        endcase
    endfunction

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // Issuing MULW straight after a 64-bit multiply is illegal
    function automatic logic mulw_legal();
        return cyc != last_mul64_cyc;
    endfunction

    // -------------------------------------------------------------------------
    // Checks
    // -------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_port(input string port, input exe_wb_instr_t wb, input logic is_mul);
        exp_entry_t e;
        if (wb.valid) begin
            if (!expected_by_tag.exists(int'(wb.tag))) begin
                error_count++;
                $display("Unexpected result on %s for tag %0d at %0d ns", port, wb.tag, $time);
            end else begin
                e = expected_by_tag[int'(wb.tag)];
                if (e.mul_port != is_mul) begin
                    error_count++;
                    $display("Tag %0d came out on the wrong port %s", wb.tag, port);
                end else if (e.due != cyc) begin
                    error_count++;
                    $display("Tag %0d on %s at cycle %0d, due at cycle %0d",
                             wb.tag, port, cyc, e.due);
                end
                check_value({port, ".rd"}, 64'(wb.rd), 64'(e.rd));
                check_value({port, ".result"}, wb.result, e.result);
                expected_by_tag.delete(int'(wb.tag));
            end
        end
    endtask

    // Outputs are registered, so the pre-edge values are stable here
    always @(posedge clk_i) begin : compare_results
        int stale[$];
        stale.delete();
        cyc = cyc + 1;
        if (rstn_i) begin
            compare_port("mul_wb_o", mul_wb_o, 1'b1);
            compare_port("alu_wb_o", alu_wb_o, 1'b0);
            foreach (expected_by_tag[k]) begin
                if (expected_by_tag[k].due <= cyc) stale.push_back(k);
            end
            foreach (stale[i]) begin
                error_count++;
                $display("Result for tag %0d missing at cycle %0d", stale[i], cyc);
                expected_by_tag.delete(stale[i]);
            end
        end
    end

    // -------------------------------------------------------------------------
    // Driver
    // -------------------------------------------------------------------------
    task automatic drive_instr(input exe_op_e op, input logic [63:0] a, input logic [63:0] b,
                               input logic flush, input logic record);
        exp_entry_t e;
        while (expected_by_tag.exists(int'(next_tag))) next_tag++;
        @(negedge clk_i);
        instruction_i.valid    = 1'b1;
        instruction_i.op       = op;
        instruction_i.rd       = 5'($urandom_range(31));
        instruction_i.tag      = next_tag;
        instruction_i.data_rs1 = a;
        instruction_i.data_rs2 = b;
        flush_i                = flush;
        if (record) begin
            e.mul_port = goes_to_mul(op);
            e.rd       = instruction_i.rd;
            e.result   = expected_result(op, a, b);
            e.due      = 32'(cyc + 1 + latency_of(op));
            expected_by_tag[int'(next_tag)] = e;
            if (goes_to_mul(op) && op != OP_MULW) last_mul64_cyc = cyc;
        end
        next_tag++;
    endtask

    task automatic issue_op(input exe_op_e op, input logic [63:0] a, input logic [63:0] b);
        drive_instr(op, a, b, 1'b0, 1'b1);
    endtask

    task automatic issue_bubble();
        @(negedge clk_i);
        instruction_i = '0;
        flush_i       = 1'b0;
    endtask

    // Flush edge drops everything that has not reached an output before it
    task automatic flush_with(input logic present, input exe_op_e op);
        int doomed[$];
        if (present) begin
            drive_instr(op, rand64(), rand64(), 1'b1, 1'b0);
            killed_count++;
        end else begin
            @(negedge clk_i);
            instruction_i = '0;
            flush_i       = 1'b1;
        end
        foreach (expected_by_tag[k]) begin
            if (expected_by_tag[k].due >= 32'(cyc + 2)) doomed.push_back(k);
        end
        foreach (doomed[i]) expected_by_tag.delete(doomed[i]);
        killed_count   += doomed.size();
        last_mul64_cyc = -10;
    endtask

    task automatic end_test(input string name);
        issue_bubble();
        while (expected_by_tag.num() != 0) issue_bubble();
        $display("Test %s: %0d checks, %0d errors", name, check_count - check_base,
                 error_count - error_base);
        check_base = check_count;
        error_base = error_count;
    endtask

    // -------------------------------------------------------------------------
    // Tests
    // -------------------------------------------------------------------------
    task automatic test_alu();
        exe_op_e     op;
        logic [63:0] b;
        for (int i = 0; i < N_ALU_RANDOM; i++) begin
            op = alu_op_at($urandom_range(10));
            b  = rand64();
            if (op inside {OP_SLL, OP_SRL, OP_SRA} && (i % 3 == 0))
                b[5:0] = (i % 2 == 0) ? 6'd0 : 6'd63;  // Upper bits stay random
            issue_op(op, rand64(), b);
        end
        issue_op(OP_SLT,  corner_value(2), corner_value(1));
        issue_op(OP_SLTU, corner_value(2), corner_value(1));
        issue_op(OP_SLT,  corner_value(1), corner_value(3));
        issue_op(OP_SLTU, corner_value(1), corner_value(3));
        issue_op(OP_SRA,  corner_value(3), 64'd63);
        issue_op(OP_SRL,  corner_value(3), 64'd63);
        issue_op(OP_SLL,  corner_value(1), 64'hffff_ffff_ffff_ffc0);
        issue_op(OP_ADDW, 64'h1234_5678_7fff_ffff, 64'd1);
        end_test("1 alu");
    endtask

    task automatic test_mul_corner(input exe_op_e op, input int n_random);
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) issue_op(op, corner_value(i), corner_value(j));
        end
        for (int i = 0; i < n_random; i++) issue_op(op, rand64(), rand64());
    endtask

    task automatic test_mulw();
        for (int i = 0; i < N_MULW; i++) issue_op(OP_MULW, rand64(), rand64());
        end_test("4 mulw");
    endtask

    task automatic test_mixed();
        int sel;
        for (int i = 0; i < N_MIXED; i++) begin
            sel = $urandom_range(9);
            if (sel < 4)
                issue_op(mul64_op_at($urandom_range(3)), rand64(), rand64());
            else if (sel < 7 || (sel < 9 && !mulw_legal()))
                issue_op(alu_op_at($urandom_range(10)), rand64(), rand64());
            else if (sel < 9)
                issue_op(OP_MULW, rand64(), rand64());
            else
                issue_bubble();
        end
        end_test("5 back-to-back");
    endtask

    task automatic test_flush();
        // Both stages busy plus an op in the flush cycle
        issue_op(OP_MUL, rand64(), rand64());
        issue_op(OP_MULH, rand64(), rand64());
        flush_with(1'b1, OP_MULHU);
        issue_op(OP_ADD, rand64(), rand64());
        issue_op(OP_MULW, rand64(), rand64());
        issue_op(OP_MULHSU, rand64(), rand64());
        issue_op(OP_SUB, rand64(), rand64());
        // MULW and ALU in flight, MULW presented with the flush
        issue_op(OP_OR, rand64(), rand64());
        issue_op(OP_MULW, rand64(), rand64());
        flush_with(1'b1, OP_MULW);
        issue_op(OP_MULW, rand64(), rand64());
        issue_op(OP_MUL, rand64(), rand64());
        issue_op(OP_XOR, rand64(), rand64());
        // Bare flush while a multiply sits in stage one
        issue_op(OP_MULHU, rand64(), rand64());
        flush_with(1'b0, OP_NOP);
        issue_op(OP_MULH, rand64(), rand64());
        issue_op(OP_SLT, rand64(), rand64());
        issue_op(OP_MULW, rand64(), rand64());
        // ALU op presented with the flush
        flush_with(1'b1, OP_AND);
        issue_op(OP_SUB, rand64(), rand64());
        end_test($sformatf("6 flush (%0d results killed)", killed_count));
    endtask

    initial begin
        void'($urandom(32'h9383_065b));
        rstn_i        = 1'b0;
        flush_i       = 1'b0;
        instruction_i = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;
        test_alu();
        test_mul_corner(OP_MUL, N_MUL_RANDOM);
        end_test("2 mul");
        test_mul_corner(OP_MULH, N_MULH_RANDOM);
        test_mul_corner(OP_MULHSU, N_MULH_RANDOM);
        test_mul_corner(OP_MULHU, N_MULH_RANDOM);
        end_test("3 mulh mulhsu mulhu");
        test_mulw();
        test_mixed();
        test_flush();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns with %0d results pending",
                 WATCHDOG_NS, expected_by_tag.num());
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
logic/exe_pkg.sv
logic/mul_unit.sv
logic/int_alu.sv
logic/exe_int_cluster.sv
testbench/tb_exe_int_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the cluster testbench with Verilator, runs it and checks the log.

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_exe_int_cluster
BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f tb.f -Mdir "$BUILD_DIR" -o "$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$SIM_LOG"; then
    exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1
